//--- verilog/dem_uart_pkg.sv
package dem_uart_pkg;

  // One flit of the debug interconnect
  // The last flag marks the final word of a packet
  typedef struct packed {
    logic        valid;
    logic        last;
    logic [15:0] data;
  } dii_flit;

  // Type word of a packet that carries characters in either direction
  localparam logic [15:0] DII_TYPE_EVENT = 16'h4000;

  // Type word of the host packet that switches the emulator on
  localparam logic [15:0] DII_TYPE_ACTIVATE = 16'h8000;

  // Outgoing packets are always addressed to the host
  localparam logic [15:0] DII_HOST_ID = 16'h0000;

  // 16550 register indices, word aligned on the bus
  localparam logic [2:0] REG_RBR_THR = 3'd0;
  localparam logic [2:0] REG_IER = 3'd1;
  localparam logic [2:0] REG_IIR = 3'd2;
  localparam logic [2:0] REG_LCR = 3'd3;
  localparam logic [2:0] REG_LSR = 3'd5;
  localparam logic [2:0] REG_SCR = 3'd7;

  // Line status bits
  localparam int LSR_DR = 0;
  localparam int LSR_THRE = 5;
  localparam int LSR_TEMT = 6;

  // Interrupt enable bits
  localparam int IER_ERBFI = 0;
  localparam int IER_ETBEI = 1;

  // Interrupt identification codes
  // Bit 0 set means that no interrupt is pending
  localparam logic [7:0] IIR_NONE = 8'h01;
  localparam logic [7:0] IIR_THRE = 8'h02;
  localparam logic [7:0] IIR_RDA = 8'h04;

endpackage

//--- verilog/uart_bus_if.sv
// Simple request/acknowledge register bus
// The master holds req and the request fields until ack
// ack lasts one cycle and rdata is valid in that cycle
interface uart_bus_if;

  logic       req;
  logic [2:0] addr;
  logic       write;
  logic [7:0] wdata;
  logic       ack;
  logic [7:0] rdata;

  modport master (
    output req, addr, write, wdata,
    input  ack, rdata
  );

  modport slave (
    input  req, addr, write, wdata,
    output ack, rdata
  );

endinterface

//--- verilog/sync_fifo.sv
// Circular buffer with an occupancy counter
// Both sides use a valid/ready handshake, and the head entry is shown without delay
module sync_fifo #(
  parameter type T = logic [7:0],
  parameter int DEPTH = 4
) (
  input  logic clk,
  input  logic arst_n_i,
  input  logic wr_valid_i,
  input  T     wr_data_i,
  output logic wr_ready_o,
  output logic rd_valid_o,
  output T     rd_data_o,
  input  logic rd_ready_i,
  output logic empty_o
);

  // A single entry buffer still needs a one bit pointer
  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  T              mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic          push;
  logic          pop;

  // Pointers wrap at DEPTH, which need not be a power of two
  function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
    if (ptr == AW'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign empty_o = (count == '0);
  assign rd_valid_o = !empty_o;
  assign wr_ready_o = (count != CW'(DEPTH));
  assign push = wr_valid_i && wr_ready_o;
  assign pop = rd_valid_o && rd_ready_i;
  assign rd_data_o = mem[rd_ptr];

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      // Simultaneous push and pop leave the count unchanged
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= wr_data_i;
    end
  end

endmodule

//--- verilog/ahb3_bus_adapter.sv
// Bridges AHB3 single transfers onto the register bus
// The address phase is captured, and the data phase becomes one bus request
module ahb3_bus_adapter #(
  parameter int XLEN = 32
) (
  input  logic            clk,
  input  logic            arst_n_i,
  input  logic            hsel_i,
  input  logic [15:0]     haddr_i,
  input  logic [XLEN-1:0] hwdata_i,
  input  logic            hwrite_i,
  input  logic [2:0]      hsize_i,
  input  logic [1:0]      htrans_i,
  output logic [XLEN-1:0] hrdata_o,
  output logic            hready_o,
  output logic            hresp_o,
  uart_bus_if.master      bus
);

  // Largest transfer size that fits the data bus
  localparam logic [2:0] HSIZE_MAX = 3'($clog2(XLEN / 8));

  logic       accept;
  logic       pending;
  logic [2:0] addr_q;
  logic       write_q;

  // NONSEQ and SEQ both have the upper htrans bit set
  // A transfer wider than the bus is illegal and treated like IDLE
  assign accept = hsel_i && htrans_i[1] && hready_o && (hsize_i <= HSIZE_MAX);

  // The data phase stalls until the register block answers
  // hready returns in the ack cycle itself, so the next address phase can overlap
  assign hready_o = !pending || bus.ack;
  assign hresp_o = 1'b0;

  assign bus.req = pending;
  assign bus.addr = addr_q;
  assign bus.write = write_q;

  // Write data is valid during the whole data phase, lane 0 only
  assign bus.wdata = hwdata_i[7:0];

  // Every byte lane sees the register value
  assign hrdata_o = {(XLEN / 8){bus.rdata}};

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pending <= 1'b0;
    end else if (accept) begin
      pending <= 1'b1;
    end else if (bus.ack) begin
      pending <= 1'b0;
    end
  end

  // Registers are word aligned, so the index sits in address bits 4 to 2
  always_ff @(posedge clk) begin
    if (accept) begin
      addr_q <= haddr_i[4:2];
      write_q <= hwrite_i;
    end
  end

endmodule

//--- verilog/dem_uart_16550.sv
// 16550 style register file on the register bus
// Transmitted characters go through the TX FIFO to the emulator
// Received characters wait in the RX FIFO until the CPU reads RBR
module dem_uart_16550 #(
  parameter int TX_DEPTH = 4,
  parameter int RX_DEPTH = 4
) (
  input  logic       clk,
  input  logic       arst_n_i,
  output logic       out_valid_o,
  output logic [7:0] out_char_o,
  input  logic       out_ready_i,
  input  logic       in_valid_i,
  input  logic [7:0] in_char_i,
  output logic       in_ready_o,
  input  logic       drop_i,
  output logic       irq_o,
  uart_bus_if.slave  bus
);

  import dem_uart_pkg::*;

  logic       thr_write;
  logic       rbr_read;
  logic       stall;
  logic       serve;
  logic       tx_wr_valid;
  logic       tx_wr_ready;
  logic       tx_empty;
  logic       rx_valid;
  logic [7:0] rx_char;
  logic [1:0] ier_q;
  logic [7:0] lcr_q;
  logic [7:0] scr_q;
  logic [7:0] lsr;
  logic [7:0] iir;
  logic [7:0] rdata_d;
  logic [7:0] rdata_q;
  logic       ack_q;

  assign thr_write = bus.req && bus.write && (bus.addr == REG_RBR_THR);

  // A THR write into a full FIFO waits for a free slot
  // With drop set the character is thrown away, so it never waits
  assign stall = thr_write && !drop_i && !tx_wr_ready;

  // A request is served once, in the cycle before its ack
  assign serve = bus.req && !ack_q && !stall;

  assign tx_wr_valid = serve && thr_write && !drop_i;
  assign rbr_read = serve && !bus.write && (bus.addr == REG_RBR_THR);

  sync_fifo #(
    .T     (logic [7:0]),
    .DEPTH (TX_DEPTH)
  ) u_tx_fifo (
    .clk        (clk),
    .arst_n_i   (arst_n_i),
    .wr_valid_i (tx_wr_valid),
    .wr_data_i  (bus.wdata),
    .wr_ready_o (tx_wr_ready),
    .rd_valid_o (out_valid_o),
    .rd_data_o  (out_char_o),
    .rd_ready_i (out_ready_i),
    .empty_o    (tx_empty)
  );

  // A read of RBR pops the head entry, if there is one
  sync_fifo #(
    .T     (logic [7:0]),
    .DEPTH (RX_DEPTH)
  ) u_rx_fifo (
    .clk        (clk),
    .arst_n_i   (arst_n_i),
    .wr_valid_i (in_valid_i),
    .wr_data_i  (in_char_i),
    .wr_ready_o (in_ready_o),
    .rd_valid_o (rx_valid),
    .rd_data_o  (rx_char),
    .rd_ready_i (rbr_read),
    .empty_o    ()
  );

  // There is no shift register behind THR
  // The transmitter counts as empty as soon as the FIFO is
  always_comb begin
    lsr = 8'h00;
    lsr[LSR_DR] = rx_valid;
    lsr[LSR_THRE] = tx_empty;
    lsr[LSR_TEMT] = tx_empty;
  end

  // Received data has priority over the THR empty interrupt
  always_comb begin
    if (ier_q[IER_ERBFI] && rx_valid) begin
      iir = IIR_RDA;
    end else if (ier_q[IER_ETBEI] && tx_empty) begin
      iir = IIR_THRE;
    end else begin
      iir = IIR_NONE;
    end
  end

  assign irq_o = (iir != IIR_NONE);

  // Unused indices read as zero
  always_comb begin
    case (bus.addr)
      REG_RBR_THR: rdata_d = rx_valid ? rx_char : 8'h00;
      REG_IER:     rdata_d = {6'b000000, ier_q};
      REG_IIR:     rdata_d = iir;
      REG_LCR:     rdata_d = lcr_q;
      REG_LSR:     rdata_d = lsr;
      REG_SCR:     rdata_d = scr_q;
      default:     rdata_d = 8'h00;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_q <= 1'b0;
      ier_q <= 2'b00;
      lcr_q <= 8'h00;
      scr_q <= 8'h00;
    end else begin
      ack_q <= serve;
      if (serve && bus.write) begin
        case (bus.addr)
          REG_IER: ier_q <= bus.wdata[1:0];
          REG_LCR: lcr_q <= bus.wdata;
          REG_SCR: scr_q <= bus.wdata;
          default: ;
        endcase
      end
    end
  end

  // read data is held for the ack cycle
  always_ff @(posedge clk) begin
    if (serve) begin
      rdata_q <= rdata_d;
    end
  end

  assign bus.ack = ack_q;
  assign bus.rdata = rdata_q;

endmodule

//--- verilog/dem_uart_emul.sv
// Debug packet side of the UART
// Each transmitted character leaves as one four flit event packet
// Incoming event packets are unpacked into the receive character stream
module dem_uart_emul (
  input  logic                  clk,
  input  logic                  arst_n_i,
  input  logic [15:0]           id_i,
  input  dem_uart_pkg::dii_flit debug_in_i,
  output logic                  debug_in_ready_o,
  output dem_uart_pkg::dii_flit debug_out_o,
  input  logic                  debug_out_ready_i,
  input  logic                  out_valid_i,
  input  logic [7:0]            out_char_i,
  output logic                  out_ready_o,
  output logic                  in_valid_o,
  output logic [7:0]            in_char_o,
  input  logic                  in_ready_i,
  output logic                  drop_o
);

  import dem_uart_pkg::*;

  typedef enum logic [1:0] {
    RX_HDR,
    RX_EVENT,
    RX_ACT,
    RX_SKIP
  } rx_mode_e;

  logic       take;
  logic       tx_busy;
  logic [1:0] tx_cnt;
  logic [7:0] char_q;
  logic       buf_wr_valid;
  logic       buf_wr_ready;
  logic       buf_rd_valid;
  dii_flit    buf_wr_flit;
  dii_flit    buf_rd_flit;
  rx_mode_e   rx_mode;
  logic [1:0] rx_cnt;
  logic       rx_fire;
  logic       active_q;

  // A character is taken only when flit 0 can go into the buffer at once
  // That puts the header on debug_out one cycle later
  assign out_ready_o = !tx_busy && buf_wr_ready;
  assign take = out_valid_i && out_ready_o;

  assign buf_wr_valid = take || tx_busy;

  // Flit 0 host address, flit 1 our id, flit 2 type, flit 3 the character
  // tx_cnt is zero whenever the sequencer is idle
  always_comb begin
    buf_wr_flit.valid = 1'b1;
    buf_wr_flit.last = 1'b0;
    case (tx_cnt)
      2'd0: buf_wr_flit.data = DII_HOST_ID;
      2'd1: buf_wr_flit.data = id_i;
      2'd2: buf_wr_flit.data = DII_TYPE_EVENT;
      default: begin
        buf_wr_flit.data = {8'h00, char_q};
        buf_wr_flit.last = 1'b1;
      end
    endcase
  end

  // The sequencer advances whenever the buffer takes a flit
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      tx_busy <= 1'b0;
      tx_cnt <= 2'd0;
    end else if (take) begin
      tx_busy <= 1'b1;
      tx_cnt <= 2'd1;
    end else if (tx_busy && buf_wr_ready) begin
      if (tx_cnt == 2'd3) begin
        tx_busy <= 1'b0;
        tx_cnt <= 2'd0;
      end else begin
        tx_cnt <= tx_cnt + 2'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      char_q <= out_char_i;
    end
  end

  // Two entries let the sequencer run ahead of a stalled debug_out
  sync_fifo #(
    .T     (dii_flit),
    .DEPTH (2)
  ) u_flit_buf (
    .clk        (clk),
    .arst_n_i   (arst_n_i),
    .wr_valid_i (buf_wr_valid),
    .wr_data_i  (buf_wr_flit),
    .wr_ready_o (buf_wr_ready),
    .rd_valid_o (buf_rd_valid),
    .rd_data_o  (buf_rd_flit),
    .rd_ready_i (debug_out_ready_i),
    .empty_o    ()
  );

  // The stored valid bit is replaced by the buffer occupancy
  always_comb begin
    debug_out_o = buf_rd_flit;
    debug_out_o.valid = buf_rd_valid;
  end

  // Header flits are always accepted
  // Event payload waits for room in the receive FIFO
  assign debug_in_ready_o = (rx_mode == RX_EVENT) ? in_ready_i : 1'b1;
  assign rx_fire = debug_in_i.valid && debug_in_ready_o;

  assign in_valid_o = debug_in_i.valid && (rx_mode == RX_EVENT);
  assign in_char_o = debug_in_i.data[7:0];

  // Characters are dropped until the host has activated the emulator
  assign drop_o = !active_q;

  // rx_cnt counts destination, source and type flits
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rx_mode <= RX_HDR;
      rx_cnt <= 2'd0;
      active_q <= 1'b0;
    end else if (rx_fire) begin
      case (rx_mode)
        RX_HDR: begin
          if (rx_cnt != 2'd2) begin
            // A packet that ends inside the header is ignored
            rx_cnt <= debug_in_i.last ? 2'd0 : rx_cnt + 2'd1;
          end else begin
            rx_cnt <= 2'd0;
            if (debug_in_i.data == DII_TYPE_ACTIVATE) begin
              // Activation takes effect when the packet is complete
              if (debug_in_i.last) begin
                active_q <= 1'b1;
              end else begin
                rx_mode <= RX_ACT;
              end
            end else if (!debug_in_i.last) begin
              rx_mode <= (debug_in_i.data == DII_TYPE_EVENT) ? RX_EVENT : RX_SKIP;
            end
          end
        end
        default: begin
          // Payload runs up to the flit marked last
          if (debug_in_i.last) begin
            rx_mode <= RX_HDR;
            if (rx_mode == RX_ACT) begin
              active_q <= 1'b1;
            end
          end
        end
      endcase
    end
  end

endmodule

//--- verilog/dem_uart_ahb3.sv
// UART emulation for the debug system with an AHB3 slave port
// hburst, hprot and hmastlock are not needed for single register transfers
module dem_uart_ahb3 #(
  parameter int XLEN = 32,
  parameter int TX_DEPTH = 4,
  parameter int RX_DEPTH = 4
) (
  input  logic                  clk,
  input  logic                  arst_n_i,
  input  logic [15:0]           id_i,
  input  dem_uart_pkg::dii_flit debug_in_i,
  output logic                  debug_in_ready_o,
  output dem_uart_pkg::dii_flit debug_out_o,
  input  logic                  debug_out_ready_i,
  output logic                  irq_o,
  input  logic                  ahb3_hsel_i,
  input  logic [15:0]           ahb3_haddr_i,
  input  logic [XLEN-1:0]       ahb3_hwdata_i,
  output logic [XLEN-1:0]       ahb3_hrdata_o,
  input  logic                  ahb3_hwrite_i,
  input  logic [2:0]            ahb3_hsize_i,
  input  logic [2:0]            ahb3_hburst_i,
  input  logic [3:0]            ahb3_hprot_i,
  input  logic [1:0]            ahb3_htrans_i,
  input  logic                  ahb3_hmastlock_i,
  output logic                  ahb3_hready_o,
  output logic                  ahb3_hresp_o
);

  // Character stream towards the debug side
  logic       out_valid;
  logic [7:0] out_char;
  logic       out_ready;

  // Character stream from the debug side
  logic       in_valid;
  logic [7:0] in_char;
  logic       in_ready;

  logic       drop;

  uart_bus_if bus_if ();

  ahb3_bus_adapter #(
    .XLEN (XLEN)
  ) u_bus_adapter (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .hsel_i   (ahb3_hsel_i),
    .haddr_i  (ahb3_haddr_i),
    .hwdata_i (ahb3_hwdata_i),
    .hwrite_i (ahb3_hwrite_i),
    .hsize_i  (ahb3_hsize_i),
    .htrans_i (ahb3_htrans_i),
    .hrdata_o (ahb3_hrdata_o),
    .hready_o (ahb3_hready_o),
    .hresp_o  (ahb3_hresp_o),
    .bus      (bus_if.master)
  );

  dem_uart_16550 #(
    .TX_DEPTH (TX_DEPTH),
    .RX_DEPTH (RX_DEPTH)
  ) u_16550 (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .out_valid_o (out_valid),
    .out_char_o  (out_char),
    .out_ready_i (out_ready),
    .in_valid_i  (in_valid),
    .in_char_i   (in_char),
    .in_ready_o  (in_ready),
    .drop_i      (drop),
    .irq_o       (irq_o),
    .bus         (bus_if.slave)
  );

  dem_uart_emul u_emul (
    .clk               (clk),
    .arst_n_i          (arst_n_i),
    .id_i              (id_i),
    .debug_in_i        (debug_in_i),
    .debug_in_ready_o  (debug_in_ready_o),
    .debug_out_o       (debug_out_o),
    .debug_out_ready_i (debug_out_ready_i),
    .out_valid_i       (out_valid),
    .out_char_i        (out_char),
    .out_ready_o       (out_ready),
    .in_valid_o        (in_valid),
    .in_char_o         (in_char),
    .in_ready_i        (in_ready),
    .drop_o            (drop)
  );

endmodule

//--- test/tb_dem_uart_ahb3.sv
// Testbench for the AHB3 debug UART
// Commands and expected values come from the golden file, one command per line
module tb_dem_uart_ahb3;

  timeunit 1ns;
  timeprecision 100ps;

  import dem_uart_pkg::*;

  localparam int XLEN = 32;
  localparam int TX_DEPTH = 4;
  localparam int RX_DEPTH = 4;
  localparam logic [15:0] DUT_ID = 16'h00a5;
  localparam logic [15:0] HOST_SRC = 16'h0001;
  localparam int QUIET_CYCLES = 16;
  localparam int CYCLES_PER_LINE = 64;
  localparam int CYCLES_EXTRA = 200;

  logic            clk;
  logic            arst_n_i;
  dii_flit         debug_in_i;
  logic            debug_in_ready_o;
  dii_flit         debug_out_o;
  logic            debug_out_ready_i;
  logic            irq_o;
  logic            ahb3_hsel_i;
  logic [15:0]     ahb3_haddr_i;
  logic [XLEN-1:0] ahb3_hwdata_i;
  logic [XLEN-1:0] ahb3_hrdata_o;
  logic            ahb3_hwrite_i;
  logic [2:0]      ahb3_hsize_i;
  logic [2:0]      ahb3_hburst_i;
  logic [3:0]      ahb3_hprot_i;
  logic [1:0]      ahb3_htrans_i;
  logic            ahb3_hmastlock_i;
  logic            ahb3_hready_o;
  logic            ahb3_hresp_o;

  // Back-pressure mode 0 keeps ready high, 1 holds it low for bp_hold cycles, 2 toggles it
  int          bp_mode;
  int          bp_hold;
  logic        ready_next;
  logic [7:0]  out_chars [$];
  int          flit_idx;
  int          test_errors;
  int          total_errors;
  int          tests_run;
  int          tests_failed;
  bit          test_open;
  logic [8*32-1:0] test_name;
  int          cycle_count;
  int          cycle_limit;

  dem_uart_ahb3 #(
    .XLEN     (XLEN),
    .TX_DEPTH (TX_DEPTH),
    .RX_DEPTH (RX_DEPTH)
  ) dem_uart_ahb3_inst (
    .clk               (clk),
    .arst_n_i          (arst_n_i),
    .id_i              (DUT_ID),
    .debug_in_i        (debug_in_i),
    .debug_in_ready_o  (debug_in_ready_o),
    .debug_out_o       (debug_out_o),
    .debug_out_ready_i (debug_out_ready_i),
    .irq_o             (irq_o),
    .ahb3_hsel_i       (ahb3_hsel_i),
    .ahb3_haddr_i      (ahb3_haddr_i),
    .ahb3_hwdata_i     (ahb3_hwdata_i),
    .ahb3_hrdata_o     (ahb3_hrdata_o),
    .ahb3_hwrite_i     (ahb3_hwrite_i),
    .ahb3_hsize_i      (ahb3_hsize_i),
    .ahb3_hburst_i     (ahb3_hburst_i),
    .ahb3_hprot_i      (ahb3_hprot_i),
    .ahb3_htrans_i     (ahb3_htrans_i),
    .ahb3_hmastlock_i  (ahb3_hmastlock_i),
    .ahb3_hready_o     (ahb3_hready_o),
    .ahb3_hresp_o      (ahb3_hresp_o)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  task automatic report_mismatch(input string msg);
    $display("FAIL %0t ns: %0s", $time, msg);
    test_errors++;
    total_errors++;
  endtask

  // Prints the result line of the running test and clears its error count
  task automatic close_test();
    if (test_open) begin
      tests_run++;
      if (test_errors == 0) begin
        $display("test %0s: passed", test_name);
      end else begin
        tests_failed++;
        $display("test %0s: failed with %0d errors", test_name, test_errors);
      end
      test_errors = 0;
    end
    test_open = 1'b0;
  endtask

  // One single AHB transfer
  // waits counts the data phase cycles with hready low
  task automatic bus_access(input logic wr, input logic [2:0] idx, input logic [7:0] wdata,
                            output logic [XLEN-1:0] rdata, output int waits);
    @(negedge clk);
    ahb3_hsel_i = 1'b1;
    ahb3_haddr_i = {11'd0, idx, 2'b00};
    ahb3_hwrite_i = wr;
    ahb3_htrans_i = 2'b10;
    @(posedge clk);
    while (!ahb3_hready_o) begin
      @(posedge clk);
    end
    // The data phase follows the address phase
    @(negedge clk);
    ahb3_hsel_i = 1'b0;
    ahb3_htrans_i = 2'b00;
    ahb3_hwdata_i = {24'd0, wdata};
    waits = 0;
    @(posedge clk);
    while (!ahb3_hready_o) begin
      waits++;
      @(posedge clk);
    end
    rdata = ahb3_hrdata_o;
    if (ahb3_hresp_o !== 1'b0) begin
      report_mismatch($sformatf("hresp_o is %b at the end of the data phase", ahb3_hresp_o));
    end
    @(negedge clk);
  endtask

  // Holds a flit on debug_in until the DUT takes it
  task automatic send_flit(input logic last, input logic [15:0] data);
    @(negedge clk);
    debug_in_i.valid = 1'b1;
    debug_in_i.last = last;
    debug_in_i.data = data;
    @(posedge clk);
    while (!debug_in_ready_o) begin
      @(posedge clk);
    end
  endtask

  // Ready for debug_out is computed at the rising edge and applied at the falling edge
  always @(posedge clk) begin
    case (bp_mode)
      0: ready_next = 1'b1;
      1: begin
        ready_next = 1'b0;
        if (bp_hold == 0) begin
          bp_mode = 2;
        end else begin
          bp_hold--;
        end
      end
      default: ready_next = 1'($urandom % 2);
    endcase
  end

  always @(negedge clk) begin
    debug_out_ready_i = ready_next;
  end

  // The flit monitor checks the header words and queues the characters for the E command
  always @(posedge clk) begin
    if (arst_n_i && debug_out_o.valid && debug_out_ready_i) begin
      if (flit_idx < 3) begin
        if (debug_out_o.last) begin
          report_mismatch($sformatf("header flit %0d has last set", flit_idx));
        end
        if (flit_idx == 0 && debug_out_o.data !== DII_HOST_ID) begin
          report_mismatch($sformatf("flit 0 is %h, not the host id", debug_out_o.data));
        end
        if (flit_idx == 1 && debug_out_o.data !== DUT_ID) begin
          report_mismatch($sformatf("flit 1 is %h, not id_i", debug_out_o.data));
        end
        if (flit_idx == 2 && debug_out_o.data !== DII_TYPE_EVENT) begin
          report_mismatch($sformatf("flit 2 is %h, not the event type", debug_out_o.data));
        end
        flit_idx++;
      end else begin
        if (!debug_out_o.last) begin
          report_mismatch("character flit does not have last set");
        end
        out_chars.push_back(debug_out_o.data[7:0]);
        flit_idx = 0;
      end
    end
  end

  // The limit is known once the golden file has been counted
  initial begin
    cycle_count = 0;
    wait (cycle_limit > 0);
    while (cycle_count < cycle_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: no result after %0d clock cycles", cycle_limit);
    $display("Simulation FAILED");
    $finish;
  end

  initial begin
    int              fd;
    int              code;
    int              waits;
    int              quiet;
    int              seed_val;
    logic [8*32-1:0] token;
    logic [8*256-1:0] line_buf;
    logic [7:0]      cmd;
    logic [15:0]     a;
    logic [15:0]     b;
    logic [15:0]     c;
    logic [XLEN-1:0] rdata;
    logic [7:0]      exp_char;
    bit              done;

    seed_val = $urandom(5919);
    arst_n_i = 1'b0;
    debug_in_i = '0;
    debug_out_ready_i = 1'b1;
    ahb3_hsel_i = 1'b0;
    ahb3_haddr_i = '0;
    ahb3_hwdata_i = '0;
    ahb3_hwrite_i = 1'b0;
    ahb3_hsize_i = 3'b010;
    ahb3_hburst_i = 3'b000;
    ahb3_hprot_i = 4'b0011;
    ahb3_htrans_i = 2'b00;
    ahb3_hmastlock_i = 1'b0;
    bp_mode = 0;
    bp_hold = 0;
    ready_next = 1'b1;
    flit_idx = 0;
    test_errors = 0;
    total_errors = 0;
    tests_run = 0;
    tests_failed = 0;
    test_open = 1'b0;
    cycle_limit = 0;

    repeat (8) @(negedge clk);
    arst_n_i = 1'b1;
    @(negedge clk);

    // Idle outputs right after reset count towards the first test
    if (ahb3_hready_o !== 1'b1) report_mismatch("hready_o is not high after reset");
    if (irq_o !== 1'b0) report_mismatch("irq_o is not low after reset");
    if (debug_out_o.valid !== 1'b0) report_mismatch("debug_out flit valid after reset");
    if (debug_in_ready_o !== 1'b1) report_mismatch("debug_in_ready_o is not high after reset");

    fd = $fopen("test/dem_uart_golden.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the golden file test/dem_uart_golden.txt");
      total_errors++;
    end else begin
      // First pass counts the lines to size the timeout
      code = 0;
      while ($fgets(line_buf, fd) != 0) begin
        code++;
      end
      $fclose(fd);
      cycle_limit = CYCLES_PER_LINE * code + CYCLES_EXTRA;
      fd = $fopen("test/dem_uart_golden.txt", "r");
      done = 1'b0;
      while (!done) begin
        code = $fscanf(fd, " %s", token);
        if (code != 1) begin
          done = 1'b1;
        end else begin
          cmd = token[7:0];
          case (cmd)
            "#": code = $fgets(line_buf, fd);
            "T": begin
              close_test();
              code = $fscanf(fd, " %s", test_name);
              test_open = 1'b1;
            end
            "W": begin
              code = $fscanf(fd, " %h %h", a, b);
              bus_access(1'b1, a[2:0], b[7:0], rdata, waits);
              if (waits != 1) begin
                report_mismatch($sformatf("write to %0d took %0d wait states", a, waits));
              end
            end
            "S": begin
              // A write that has to wait for debug_out back-pressure to end
              code = $fscanf(fd, " %h %h", a, b);
              bus_access(1'b1, a[2:0], b[7:0], rdata, waits);
              if (waits < 2) begin
                report_mismatch($sformatf("write to %0d did not stall", a));
              end
              if (bp_mode == 1) begin
                report_mismatch("stalled write ended while debug_out_ready_i was held low");
              end
            end
            "R": begin
              code = $fscanf(fd, " %h %h", a, b);
              bus_access(1'b0, a[2:0], 8'h00, rdata, waits);
              if (rdata !== {4{b[7:0]}}) begin
                report_mismatch($sformatf("read of %0d gave %h, expected %h in all lanes",
                                          a, rdata, b[7:0]));
              end
              if (waits != 1) begin
                report_mismatch($sformatf("read of %0d took %0d wait states", a, waits));
              end
            end
            "P": begin
              code = $fscanf(fd, " %h %h", a, b);
              send_flit(1'b0, 16'h0000);
              send_flit(1'b0, HOST_SRC);
              send_flit(b == 0, a);
              for (int i = 0; i < b; i++) begin
                code = $fscanf(fd, " %h", c);
                send_flit(i == b - 1, {8'h00, c[7:0]});
              end
              @(negedge clk);
              debug_in_i = '0;
            end
            "E": begin
              code = $fscanf(fd, " %h", a);
              while (out_chars.size() == 0) begin
                @(negedge clk);
              end
              exp_char = out_chars.pop_front();
              if (exp_char !== a[7:0]) begin
                report_mismatch($sformatf("packet carried %h, expected %h", exp_char, a[7:0]));
              end
            end
            "B": begin
              code = $fscanf(fd, " %h %h", a, b);
              @(negedge clk);
              bp_mode = a;
              bp_hold = b;
            end
            "I": begin
              code = $fscanf(fd, " %h", a);
              if (irq_o !== a[0]) begin
                report_mismatch($sformatf("irq_o is %b, expected %b", irq_o, a[0]));
              end
            end
            "Q": begin
              quiet = 0;
              while (quiet < QUIET_CYCLES) begin
                @(negedge clk);
                quiet = debug_out_o.valid ? 0 : quiet + 1;
              end
              if (out_chars.size() != 0 || flit_idx != 0) begin
                report_mismatch($sformatf("%0d unexpected packets on debug_out",
                                          out_chars.size()));
                out_chars.delete();
              end
            end
            default: begin
              $display("Unknown command %0s in the golden file", token);
              total_errors++;
              code = $fgets(line_buf, fd);
            end
          endcase
        end
      end
      $fclose(fd);
      close_test();
    end

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, total_errors);
    if (total_errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- test/dem_uart_golden.txt
# Each line: command letter, then hex fields. T name, W reg value, R reg expected,
# P type count chars, E char, B mode hold, I irq, S reg value (stalling write), Q
T reset
R 5 60
R 2 01
I 0
T drop
W 0 41
W 0 42
Q
R 5 60
T transmit
P 8000 0
W 0 48
W 0 49
E 48
E 49
Q
W 7 5a
R 7 5a
W 3 03
R 3 03
T receive
P 4000 3 61 62 63
R 5 61
W 1 01
R 2 04
I 1
R 0 61
R 0 62
I 1
R 0 63
I 0
R 0 00
W 1 02
R 2 02
I 1
W 1 00
I 0
T backpressure
B 1 40
W 0 31
W 0 32
W 0 33
W 0 34
W 0 35
S 0 36
E 31
E 32
E 33
E 34
E 35
E 36
Q
B 0 0
R 5 60

//--- sim.f
verilog/dem_uart_pkg.sv
verilog/uart_bus_if.sv
verilog/sync_fifo.sv
verilog/ahb3_bus_adapter.sv
verilog/dem_uart_16550.sv
verilog/dem_uart_emul.sv
verilog/dem_uart_ahb3.sv
test/tb_dem_uart_ahb3.sv
